// File: compile.f
+incdir+source
source/dlxPkg.sv
source/instrQueue.sv
source/control.sv
source/alu.sv
source/resultQueue.sv
source/dlxExec.sv
verif/dlxExec_asserts.sv
verif/dlxExecTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the dlxExec testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module dlxExecTb \
    --Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: verif/dlxExecTb.sv
`include "dlx_cfg.svh"

module dlxExecTb import dlxPkg::*; ();
    logic clk, rst, inValid, inCredit, outValid, outWrite, outTaken, outCredit;
    instrT  inInstr;
    wordT   inRs1Val, inRs2Val, outResult;
    regIdxT outDest;

    logic [31:0] tInstr[$], tRs1[$], tRs2[$], tResult[$]; // stimulus table
    logic [4:0]  tDest[$];
    logic        tWrite[$], tTaken[$];
    logic [31:0] lcgState = 32'h6d97_15c2;
    logic [31:0] rnd;
    int numRows, sendIdx, recvIdx, upCredits, owed, creditPulses, cycles;

    dlxExec dlxExec_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // big-endian fields: opcode, rs1, rs2, rd, unused, func
    function automatic logic [31:0] rEnc(input logic [5:0] func, input logic [4:0] rd);
        return {6'h00, 5'd1, 5'd2, rd, 5'd0, func};
    endfunction

    function automatic logic [31:0] iEnc(input logic [5:0] op, input logic [4:0] rd,
                                         input logic [15:0] imm);
        return {op, 5'd1, rd, imm};
    endfunction

    task automatic addRow(input logic [31:0] instr, rs1, rs2, res, input logic [4:0] dest,
                          input logic wr, tk);
        tInstr.push_back(instr);
        tRs1.push_back(rs1);
        tRs2.push_back(rs2);
        tResult.push_back(res);
        tDest.push_back(dest);
        tWrite.push_back(wr);
        tTaken.push_back(tk);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // ends a run that stops making progress
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 40 * tInstr.size() + 100) begin
            $display("timeout: results still missing after %0d cycles", cycles);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst = 1'b1;
        inValid = 1'b0;
        inInstr = '0;
        inRs1Val = '0;
        inRs2Val = '0;
        outCredit = 1'b0;
        cycles = 0;
        addRow(rEnc(6'h20, 5'd3), 32'h10, 32'h5, 32'h15, 5'd3, 1'b1, 1'b0); // add
        addRow(rEnc(6'h22, 5'd4), 32'h10, 32'h20, 32'hffff_fff0, 5'd4, 1'b1, 1'b0);
        addRow(rEnc(6'h24, 5'd5), 32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200, 5'd5, 1'b1, 1'b0);
        addRow(rEnc(6'h25, 5'd6), 32'hf0f0_0000, 32'h1234, 32'hf0f0_1234, 5'd6, 1'b1, 1'b0);
        addRow(rEnc(6'h26, 5'd7), 32'hffff_0000, 32'h0f0f_0f0f, 32'hf0f0_0f0f, 5'd7, 1'b1, 1'b0);
        addRow(rEnc(6'h04, 5'd8), 32'h3, 32'h24, 32'h30, 5'd8, 1'b1, 1'b0); // shamt is 4
        addRow(rEnc(6'h06, 5'd9), 32'h8000_0000, 32'h4, 32'h0800_0000, 5'd9, 1'b1, 1'b0);
        addRow(rEnc(6'h07, 5'd10), 32'h8000_0000, 32'h4, 32'hf800_0000, 5'd10, 1'b1, 1'b0);
        addRow(rEnc(6'h2a, 5'd11), 32'hffff_fff0, 32'h5, 32'h1, 5'd11, 1'b1, 1'b0); // slt
        addRow(rEnc(6'h2c, 5'd12), 32'h5, 32'h5, 32'h1, 5'd12, 1'b1, 1'b0);
        addRow(rEnc(6'h2b, 5'd13), 32'hffff_fff0, 32'h5, 32'h0, 5'd13, 1'b1, 1'b0);
        addRow(rEnc(6'h2d, 5'd14), 32'h5, 32'hffff_fff0, 32'h1, 5'd14, 1'b1, 1'b0);
        addRow(rEnc(6'h28, 5'd15), 32'h7, 32'h7, 32'h1, 5'd15, 1'b1, 1'b0); // seq
        addRow(rEnc(6'h29, 5'd16), 32'h7, 32'h7, 32'h0, 5'd16, 1'b1, 1'b0);
        addRow(iEnc(6'h08, 5'd17, 16'hfff0), 32'h100, 32'hdead_beef, 32'hf0, 5'd17, 1'b1, 1'b0);
        addRow(iEnc(6'h09, 5'd18, 16'hfff0), 32'h100, 32'h0, 32'h1_00f0, 5'd18, 1'b1, 1'b0);
        addRow(iEnc(6'h0a, 5'd19, 16'hffff), 32'h10, 32'h0, 32'h11, 5'd19, 1'b1, 1'b0); // subi
        addRow(iEnc(6'h0b, 5'd20, 16'h8000), 32'h10_0000, 32'h0, 32'hf_8000, 5'd20, 1'b1, 1'b0);
        addRow(iEnc(6'h0c, 5'd21, 16'h8f0f), 32'h1234_5678, 32'h0, 32'h1234_0608, 5'd21, 1'b1, 1'b0);
        addRow(iEnc(6'h1a, 5'd22, 16'hfff8), 32'hffff_fff0, 32'h0, 32'h1, 5'd22, 1'b1, 1'b0);
        addRow(iEnc(6'h17, 5'd23, 16'h0008), 32'hf000_0000, 32'h0, 32'hfff0_0000, 5'd23, 1'b1, 1'b0);
        addRow(iEnc(6'h0f, 5'd24, 16'hbeef), 32'h0, 32'h0, 32'hbeef_0000, 5'd24, 1'b1, 1'b0); // lhi
        addRow(iEnc(6'h04, 5'd2, 16'h0010), 32'h0, 32'h0, 32'h0, 5'd2, 1'b0, 1'b1); // beqz
        addRow(iEnc(6'h04, 5'd2, 16'h0010), 32'h5, 32'h0, 32'h0, 5'd2, 1'b0, 1'b0);
        addRow(iEnc(6'h05, 5'd2, 16'h0020), 32'h5, 32'h0, 32'h0, 5'd2, 1'b0, 1'b1); // bnez
        addRow(iEnc(6'h05, 5'd2, 16'h0020), 32'h0, 32'h0, 32'h0, 5'd2, 1'b0, 1'b0);
        addRow(32'h0, 32'h1234_5678, 32'h1, 32'h0, 5'd0, 1'b0, 1'b0); // nop
        numRows = tInstr.size();
        sendIdx = 0;
        recvIdx = 0;
        upCredits = `DLX_IN_DEPTH;
        owed = 0;
        creditPulses = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (recvIdx < numRows) begin
            @(posedge clk);
            if (inCredit) begin
                upCredits++;
                creditPulses++;
            end
            check(32'(upCredits <= `DLX_IN_DEPTH), 32'd1, "upstream credits within depth");
            if (outValid) begin
                check(32'(recvIdx < sendIdx), 32'd1, "result before its instruction");
                check(outResult, tResult[recvIdx], $sformatf("row %0d result", recvIdx));
                check(32'(outDest), 32'(tDest[recvIdx]), $sformatf("row %0d dest", recvIdx));
                check(32'(outWrite), 32'(tWrite[recvIdx]), $sformatf("row %0d write", recvIdx));
                check(32'(outTaken), 32'(tTaken[recvIdx]), $sformatf("row %0d taken", recvIdx));
                recvIdx++;
                owed++; // downstream hands this credit back later
            end
            rnd = lcgNext();
            if (sendIdx < numRows && upCredits > 0 && rnd[31:30] != 2'b00) begin
                inValid  <= 1'b1;
                inInstr  <= tInstr[sendIdx];
                inRs1Val <= tRs1[sendIdx];
                inRs2Val <= tRs2[sendIdx];
                upCredits--;
                sendIdx++;
            end else begin
                inValid <= 1'b0;
            end
            // credits trickle back so the result queue fills up now and then
            if (owed > 0 && rnd[27:25] < 3'd3) begin
                outCredit <= 1'b1;
                owed--;
            end else begin
                outCredit <= 1'b0;
            end
        end
        check(32'(creditPulses), 32'(numRows), "inCredit pulse count");
        $display("No errors");
        $finish;
    end

endmodule

// File: verif/dlxExec_asserts.sv
`include "dlx_cfg.svh"

module dlxExecAsserts (
    input logic                           clk,
    input logic                           rst,
    input logic                           inValid,
    input logic                           inCredit,
    input logic                           outValid,
    input logic                           outCredit,
    input logic [$clog2(`DLX_IN_DEPTH):0] inCount  // instruction queue occupancy
);
    localparam int CRED_W = `DLX_CRED_W;

    logic [CRED_W-1:0] heldCredits; // downstream credits as seen on the ports

    always_ff @(posedge clk) begin
        if (rst) heldCredits <= CRED_W'(`DLX_OUT_CREDITS);
        else heldCredits <= heldCredits - CRED_W'(outValid) + CRED_W'(outCredit);
    end

    // upstream must hold a credit, so the queue is never written while full
    noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
        !(inValid && inCount == `DLX_IN_DEPTH))
        else $error("upstream wrote into a full instruction queue");

    noSendWithoutCredit: assert property (@(posedge clk) disable iff (rst)
        outValid |-> heldCredits != 0)
        else $error("result sent with no downstream credit");

    // first cycle out of reset is quiet on both sides
    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !inCredit && !outValid)
        else $error("credit or result activity right after reset");

endmodule

bind dlxExec dlxExecAsserts dlxExecAsserts_i (
    .clk, .rst, .inValid, .inCredit, .outValid, .outCredit,
    .inCount(instrQueue_i.count)
);

// File: source/dlxExec.sv
module dlxExec import dlxPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   inValid,
    input  instrT  inInstr,
    input  wordT   inRs1Val,
    input  wordT   inRs2Val,
    output logic   inCredit,
    output logic   outValid,
    output wordT   outResult,
    output regIdxT outDest,
    output logic   outWrite,
    output logic   outTaken,
    input  logic   outCredit
);
    logic   headValid;
    instrT  headInstr;
    wordT   headRs1Val;
    wordT   headRs2Val;
    logic   pop;
    aluOpT  aluOp;
    logic   rType, regWrite, branch, branchZero, extOp, lhiOp; // decoder controls
    logic   space;
    logic   push;
    wordT   result;
    regIdxT dest;
    logic   write, taken;

    instrQueue instrQueue_i (
        .clk, .rst, .inValid, .inInstr, .inRs1Val, .inRs2Val,
        .pop, .headValid, .headInstr, .headRs1Val, .headRs2Val, .inCredit
    );

    control control_i (
        .instruction(headInstr),
        .aluOp, .rType, .regWrite, .branch, .branchZero, .extOp, .lhiOp
    );

    alu alu_i (
        .clk, .rst, .headValid, .headInstr, .headRs1Val, .headRs2Val,
        .aluOp, .rType, .regWrite, .branch, .branchZero, .extOp, .lhiOp,
        .space, .pop, .push, .result, .dest, .write, .taken
    );

    resultQueue resultQueue_i (
        .clk, .rst, .push, .result, .dest, .write, .taken, .space,
        .outValid, .outResult, .outDest, .outWrite, .outTaken, .outCredit
    );

endmodule

// File: source/resultQueue.sv
`include "dlx_cfg.svh"

module resultQueue import dlxPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  wordT   result,
    input  regIdxT dest,
    input  logic   write,
    input  logic   taken,
    output logic   space,
    output logic   outValid,
    output wordT   outResult,
    output regIdxT outDest,
    output logic   outWrite,
    output logic   outTaken,
    input  logic   outCredit
);
    localparam int DEPTH  = `DLX_OUT_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CRED_W = `DLX_CRED_W;

    wordT              resMem [DEPTH];
    regIdxT            destMem [DEPTH];
    logic              writeMem [DEPTH];
    logic              takenMem [DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [PTR_W:0]    count;
    logic [CRED_W-1:0] credits; // downstream credits on hand

    assign space     = (DEPTH - int'(count)) >= 2; // one slot kept for the push in flight
    assign outValid  = (count != '0) && (credits != '0);
    assign outResult = resMem[rdPtr];
    assign outDest   = destMem[rdPtr];
    assign outWrite  = writeMem[rdPtr];
    assign outTaken  = takenMem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            resMem[wrPtr]   <= result;
            destMem[wrPtr]  <= dest;
            writeMem[wrPtr] <= write;
            takenMem[wrPtr] <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            credits <= CRED_W'(`DLX_OUT_CREDITS);
        end else begin
            if (push) wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (outValid) rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            if (push && !outValid) count <= count + 1'b1;
            else if (outValid && !push) count <= count - 1'b1;
            if (outValid && !outCredit) credits <= credits - 1'b1;
            else if (outCredit && !outValid) credits <= credits + 1'b1;
        end
    end

endmodule

// File: source/alu.sv
module alu import dlxPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   headValid,
    input  instrT  headInstr,
    input  wordT   headRs1Val,
    input  wordT   headRs2Val,
    input  aluOpT  aluOp,
    input  logic   rType,
    input  logic   regWrite,
    input  logic   branch,
    input  logic   branchZero,
    input  logic   extOp,
    input  logic   lhiOp,
    input  logic   space,
    output logic   pop,
    output logic   push,
    output wordT   result,
    output regIdxT dest,
    output logic   write,
    output logic   taken
);
    logic [15:0] imm;
    wordT        extImm;
    wordT        opB;
    wordT        aluRes;
    logic [4:0]  shamt;
    logic        rs1Zero;

    assign imm     = headInstr[16:31];
    assign extImm  = extOp ? wordT'($signed(imm)) : wordT'(imm);
    assign opB     = rType ? headRs2Val : extImm;
    assign shamt   = opB[4:0];
    assign rs1Zero = (headRs1Val == '0);
    assign pop     = headValid && space;

    always_comb begin
        case (aluOp)
            ALU_SUB: aluRes = headRs1Val - opB;
            ALU_SLT: aluRes = wordT'($signed(headRs1Val) < $signed(opB));
            ALU_SLE: aluRes = wordT'($signed(headRs1Val) <= $signed(opB));
            ALU_SGT: aluRes = wordT'($signed(headRs1Val) > $signed(opB));
            ALU_SGE: aluRes = wordT'($signed(headRs1Val) >= $signed(opB));
            ALU_SEQ: aluRes = wordT'(headRs1Val == opB);
            ALU_SNE: aluRes = wordT'(headRs1Val != opB);
            ALU_SLL: aluRes = headRs1Val << shamt;
            ALU_SRL: aluRes = headRs1Val >> shamt;
            ALU_SRA: aluRes = $signed(headRs1Val) >>> shamt;
            ALU_AND: aluRes = headRs1Val & opB;
            ALU_OR:  aluRes = headRs1Val | opB;
            ALU_XOR: aluRes = headRs1Val ^ opB;
            default: aluRes = headRs1Val + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) push <= 1'b0;
        else push <= pop; // result reaches the output fifo one cycle after the pop
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            // branches and nops carry a zero result
            result <= !regWrite ? '0 : (lhiOp ? wordT'({imm, 16'h0000}) : aluRes);
            dest   <= rType ? headInstr[16:20] : headInstr[11:15];
            write  <= regWrite;
            taken  <= branch && (branchZero ? rs1Zero : !rs1Zero);
        end
    end

endmodule

// File: source/control.sv
module control import dlxPkg::*; (
    input  instrT instruction,
    output aluOpT aluOp,
    output logic  rType,
    output logic  regWrite,
    output logic  branch,
    output logic  branchZero,
    output logic  extOp,
    output logic  lhiOp
);
    opcodeT opcode;
    funcT   func;
    logic   isZero;

    assign opcode = instruction[0:5];
    assign func   = instruction[26:31];
    assign isZero = (instruction == '0); // nop, every control stays low

    always_comb begin
        aluOp      = ALU_ADD;
        rType      = 1'b0;
        regWrite   = 1'b0;
        branch     = 1'b0;
        branchZero = 1'b0;
        extOp      = 1'b0;
        lhiOp      = 1'b0;
        if (!isZero) begin
            // only ADDUI and SUBUI take a zero-extended immediate
            extOp = (opcode != 6'h09) && (opcode != 6'h0b);
            case (opcode)
                6'h00: begin
                    rType    = 1'b1;
                    regWrite = 1'b1;
                    case (func)
                        6'h04: aluOp = ALU_SLL;
                        6'h06: aluOp = ALU_SRL;
                        6'h07: aluOp = ALU_SRA;
                        6'h20, 6'h21: aluOp = ALU_ADD; // add, addu
                        6'h22, 6'h23: aluOp = ALU_SUB; // sub, subu
                        6'h24: aluOp = ALU_AND;
                        6'h25: aluOp = ALU_OR;
                        6'h26: aluOp = ALU_XOR;
                        6'h28: aluOp = ALU_SEQ;
                        6'h29: aluOp = ALU_SNE;
                        6'h2a: aluOp = ALU_SLT;
                        6'h2b: aluOp = ALU_SGT;
                        6'h2c: aluOp = ALU_SLE;
                        6'h2d: aluOp = ALU_SGE;
                        default: regWrite = 1'b0; // unknown function writes nothing
                    endcase
                end
                6'h04, 6'h05: begin
                    branch     = 1'b1;
                    branchZero = !opcode[5]; // beqz is 0x04
                end
                6'h0f: begin
                    // lhi, the execute stage builds the upper half itself
                    aluOp    = ALU_SLL;
                    lhiOp    = 1'b1;
                    regWrite = 1'b1;
                end
                6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e,
                6'h14, 6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h1c, 6'h1d: begin
                    regWrite = 1'b1;
                    case (opcode)
                        6'h0a, 6'h0b: aluOp = ALU_SUB;
                        6'h0c: aluOp = ALU_AND;
                        6'h0d: aluOp = ALU_OR;
                        6'h0e: aluOp = ALU_XOR;
                        6'h14: aluOp = ALU_SLL;
                        6'h16: aluOp = ALU_SRL;
                        6'h17: aluOp = ALU_SRA;
                        6'h18: aluOp = ALU_SEQ;
                        6'h19: aluOp = ALU_SNE;
                        6'h1a: aluOp = ALU_SLT;
                        6'h1b: aluOp = ALU_SGT;
                        6'h1c: aluOp = ALU_SLE;
                        6'h1d: aluOp = ALU_SGE;
                        default: aluOp = ALU_ADD; // addi, addui
                    endcase
                end
                default: ; // jumps, memory and fp are outside this slice
            endcase
        end
    end

endmodule

// File: source/instrQueue.sv
`include "dlx_cfg.svh"

module instrQueue import dlxPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  inValid,
    input  instrT inInstr,
    input  wordT  inRs1Val,
    input  wordT  inRs2Val,
    input  logic  pop,
    output logic  headValid,
    output instrT headInstr,
    output wordT  headRs1Val,
    output wordT  headRs2Val,
    output logic  inCredit
);
    localparam int DEPTH = `DLX_IN_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    instrT            instrMem [DEPTH];
    wordT             rs1Mem [DEPTH];
    wordT             rs2Mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count; // occupancy, 0 to DEPTH
    logic             full;
    logic             wrEn;
    logic             rdEn;

    assign full = (count == (PTR_W + 1)'(DEPTH));
    assign wrEn = inValid && !full; // upstream credits keep this from ever blocking
    assign rdEn = pop && headValid;

    assign headValid  = (count != '0);
    assign headInstr  = instrMem[rdPtr];
    assign headRs1Val = rs1Mem[rdPtr];
    assign headRs2Val = rs2Mem[rdPtr];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            instrMem[wrPtr] <= inInstr;
            rs1Mem[wrPtr]   <= inRs1Val;
            rs2Mem[wrPtr]   <= inRs2Val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            inCredit <= 1'b0;
        end else begin
            inCredit <= rdEn; // one credit back per released entry
            if (wrEn) wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (rdEn) rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            if (wrEn && !rdEn) count <= count + 1'b1;
            else if (rdEn && !wrEn) count <= count - 1'b1;
        end
    end

endmodule

// File: source/dlxPkg.sv
`include "dlx_cfg.svh"

package dlxPkg;

    // big-endian numbering, bit 0 is the opcode msb
    typedef logic [0:31] instrT;

    typedef logic [`DLX_DATA_W-1:0] wordT;
    typedef logic [4:0] regIdxT;
    typedef logic [0:5] opcodeT; // primary opcode, instruction bits 0 to 5
    typedef logic [0:5] funcT;   // r-type function, instruction bits 26 to 31

    // alu operation codes as produced by the decoder
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b0001,
        ALU_SLT = 4'b0010,
        ALU_SLE = 4'b0011,
        ALU_SGT = 4'b0100,
        ALU_SGE = 4'b0101,
        ALU_SRA = 4'b0111,
        ALU_SLL = 4'b1001,
        ALU_SRL = 4'b1010,
        ALU_SEQ = 4'b1011,
        ALU_SNE = 4'b1100,
        ALU_AND = 4'b1101,
        ALU_OR  = 4'b1110,
        ALU_XOR = 4'b1111
    } aluOpT;

endpackage

// File: source/dlx_cfg.svh
`ifndef DLX_CFG_SVH
`define DLX_CFG_SVH

// instruction queue entries, upstream holds this many credits after reset
`define DLX_IN_DEPTH 4

// result queue entries
`define DLX_OUT_DEPTH 4

// downstream credits loaded into the result queue counter at reset
`define DLX_OUT_CREDITS 2

`define DLX_CRED_W 3 // wide enough for the granted credits

// operand and result width
`define DLX_DATA_W 32

`endif
